// ==== common/chipBusPkg.sv ====
package chipBusPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    typedef logic [23:0] cpuAddr_t;     // CPU byte address
    typedef logic [7:0]  regOffset_t;   // Word offset inside the register window

    // Register window at 0xDFF000, top 12 address bits compared
    localparam cpuAddr_t REG_BASE = 24'hDFF000;
    localparam cpuAddr_t REG_MASK = 24'hFFF000;

    //////////////////////////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////////////////////////

    // One-cycle pulses, one per C1/C3 phase edge
    typedef struct packed {
        logic c3Fall;   // Start of S2 when C1 is low
        logic c3Rise;   // S4 sample point
        logic c1Fall;   // S5, early read termination
        logic c1Rise;   // S7, end of cycle
    } phaseEvents_t;

    // Latched register request
    typedef struct packed {
        logic       rnw;        // High for read
        logic       upper;      // Upper byte lane, D15..D8
        logic       lower;      // Lower byte lane, D7..D0
        regOffset_t offset;     // Address bits 8..1
    } regRequest_t;

    //////////////////////////////////////////////////////////////////////
    // Sequencer states
    //////////////////////////////////////////////////////////////////////

    // Named after the MC68000 bus states they stand for
    typedef enum logic [2:0] {
        s2Idle = 3'd0,  // Waiting for a request on C3 fall
        s4Wait = 3'd1,  // Data strobes on, wait states while Agnus holds the bus
        s5Read = 3'd2,  // Read data latched early on C1 fall
        s6Hold = 3'd3,  // Hold until C3 falls
        s7End  = 3'd4   // Release strobes on C1 rise
    } regState_t;

endpackage

// ==== hdl/clockPhaseTracker.sv ====
`timescale 1ns/100ps

module clockPhaseTracker (
    input  logic                     CLK40,
    input  logic                     nRESET,
    input  logic                     C1,
    input  logic                     C3,
    output chipBusPkg::phaseEvents_t phase
);

    // Bit 0 and 1 are the sync stages, bit 2 the previous synced level
    logic [2:0] c1Hist;
    logic [2:0] c3Hist;
    logic [1:0] fillCount;  // Counts up until the history holds real samples
    logic       c1Moved;
    logic       c3Moved;
    chipBusPkg::phaseEvents_t phaseNext;

    assign c1Moved = c1Hist[1] ^ c1Hist[2];
    assign c3Moved = c3Hist[1] ^ c3Hist[2];

    // Legal order of (C1,C3) is 00 -> 10 -> 11 -> 01 -> 00
    // Each edge is one clock changing while the other holds its level
    always_comb begin
        phaseNext.c1Rise = c1Moved &&  c1Hist[1] && !c3Moved && !c3Hist[1];    // 00 -> 10
        phaseNext.c3Rise = c3Moved &&  c3Hist[1] && !c1Moved &&  c1Hist[1];    // 10 -> 11
        phaseNext.c1Fall = c1Moved && !c1Hist[1] && !c3Moved &&  c3Hist[1];    // 11 -> 01
        phaseNext.c3Fall = c3Moved && !c3Hist[1] && !c1Moved && !c1Hist[1];    // 01 -> 00
    end

    //////////////////////////////////////////////////////////////////////
    // Synchronizers and edge stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            c1Hist    <= '1;
            c3Hist    <= '1;
            fillCount <= '0;
            phase     <= '0;
        end else begin
            c1Hist <= {c1Hist[1:0], C1};
            c3Hist <= {c3Hist[1:0], C3};
            if (fillCount != 2'd3) begin
                fillCount <= fillCount + 2'd1;
            end
            phase <= phaseNext;     // Pulse three cycles after the pin change
        end
    end

    // C1 and C3 are in quadrature, never both move at once
    a_oneClockMoves : assert property (@(posedge CLK40)
        disable iff (!nRESET || fillCount != 2'd3) !(c1Moved && c3Moved))
        else $error("C1 and C3 changed in the same cycle");

endmodule

// ==== chipReg/regSpaceDecoder.sv ====
`timescale 1ns/100ps

module regSpaceDecoder (
    input  logic                    CLK40,
    input  logic                    nRESET,
    input  logic                    tStart,
    input  chipBusPkg::cpuAddr_t    addr,
    input  logic                    rnw,
    input  logic [1:0]              siz,
    input  logic                    regTa,
    output logic                    regPending,
    output chipBusPkg::regRequest_t request
);

    logic                    inWindow;
    logic                    accept;
    chipBusPkg::regRequest_t decoded;

    // Only the top 12 bits select the chip register window
    assign inWindow = (addr & chipBusPkg::REG_MASK) ==
                      (chipBusPkg::REG_BASE & chipBusPkg::REG_MASK);
    assign accept   = tStart && inWindow && !regPending;    // Busy starts are dropped

    // Byte lanes from SIZ and A0, as a 68000 would drive UDS and LDS
    always_comb begin
        decoded.rnw    = rnw;
        decoded.upper  = !addr[0];                      // Even byte or word
        decoded.lower  = siz[1] || !siz[0] || addr[0];  // Odd byte, word or long
        decoded.offset = addr[8:1];
    end

    //////////////////////////////////////////////////////////////////////
    // Pending flag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            regPending <= 1'b0;
        end else if (regTa) begin
            regPending <= 1'b0;     // Released by the acknowledge
        end else if (accept) begin
            regPending <= 1'b1;
        end
    end

    // Request payload
    always_ff @(posedge CLK40) begin
        if (accept) begin
            request <= decoded;
        end
    end

endmodule

// ==== chipReg/chipRegisterCycle.sv ====
`timescale 1ns/100ps

module chipRegisterCycle (
    input  logic                     CLK40,
    input  logic                     nRESET,
    input  chipBusPkg::phaseEvents_t phase,
    input  logic                     regPending,
    input  chipBusPkg::regRequest_t  request,
    input  logic                     nDBR,      // Agnus DMA owns the bus when low
    input  logic                     casAgnus,  // Agnus CAS cycle in progress
    output logic                     nAS,
    output logic                     nUDS,
    output logic                     nLDS,
    output logic                     nREGEN,
    output logic                     regTa,
    output logic                     regCycle,
    output chipBusPkg::regOffset_t   regOffset
);

    chipBusPkg::regState_t state;

    logic asEn;         // Address strobe
    logic dsEn;         // Data strobe enable, gated with the lanes
    logic regEn;        // Register buffer enable
    logic cycleRnw;     // Direction of the running cycle
    logic laneUpper;
    logic laneLower;
    logic busFree;

    // Agnus lets go when DBR is negated and no CAS cycle is running
    assign busFree = nDBR && !casAgnus;

    assign nAS    = !asEn;
    assign nREGEN = !regEn;
    assign nUDS   = !(laneUpper && dsEn);
    assign nLDS   = !(laneLower && dsEn);

    //////////////////////////////////////////////////////////////////////
    // MC68000 register cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            state    <= chipBusPkg::s2Idle;
            asEn     <= 1'b0;
            dsEn     <= 1'b0;
            regEn    <= 1'b0;
            regTa    <= 1'b0;
            regCycle <= 1'b0;
        end else begin
            regTa <= 1'b0;  // Acknowledge is a single pulse
            case (state)
                chipBusPkg::s2Idle: begin
                    // Cycles start with C1 and C3 both low
                    if (phase.c3Fall && regPending) begin
                        asEn     <= 1'b1;
                        regEn    <= 1'b1;
                        dsEn     <= request.rnw;    // Read strobes go with AS
                        regCycle <= 1'b1;
                        state    <= chipBusPkg::s4Wait;
                    end else begin
                        regCycle <= 1'b0;
                    end
                end

                chipBusPkg::s4Wait: begin
                    if (phase.c3Rise) begin
                        dsEn <= 1'b1;               // Write strobes come here
                        if (busFree) begin
                            state <= chipBusPkg::s5Read;
                        end                         // Else wait for the next C3 rise
                    end
                end

                chipBusPkg::s5Read: begin
                    if (phase.c1Fall) begin
                        regTa <= cycleRnw;          // Early termination for reads
                        state <= chipBusPkg::s6Hold;
                    end
                end

                chipBusPkg::s6Hold: begin
                    if (phase.c3Fall) begin
                        state <= chipBusPkg::s7End;
                    end
                end

                chipBusPkg::s7End: begin
                    if (phase.c1Rise) begin
                        asEn  <= 1'b0;
                        dsEn  <= 1'b0;
                        regEn <= 1'b0;
                        regTa <= !cycleRnw;         // Writes end with the strobes
                        state <= chipBusPkg::s2Idle;
                    end
                end

                default: state <= chipBusPkg::s2Idle;
            endcase
        end
    end

    // Lanes, direction and offset held for the whole cycle
    always_ff @(posedge CLK40) begin
        if (state == chipBusPkg::s2Idle && phase.c3Fall && regPending) begin
            cycleRnw  <= request.rnw;
            laneUpper <= request.upper;
            laneLower <= request.lower;
            regOffset <= request.offset;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bus rules
    //////////////////////////////////////////////////////////////////////

    a_dsInsideAs : assert property (@(posedge CLK40) disable iff (!nRESET)
        (!nUDS || !nLDS) |-> !nAS)
        else $error("Data strobe low while AS is high");

    a_taSingle : assert property (@(posedge CLK40) disable iff (!nRESET)
        regTa |=> !regTa)
        else $error("Acknowledge longer than one cycle");

    // Write acknowledge lands in the cycle where REGEN goes high
    a_taInCycle : assert property (@(posedge CLK40) disable iff (!nRESET)
        regTa |-> (!nREGEN || $rose(nREGEN)))
        else $error("Acknowledge outside a register cycle");

endmodule

// ==== hdl/chipBusTop.sv ====
`timescale 1ns/100ps

module chipBusTop (
    input  logic                   CLK40,
    input  logic                   nRESET,
    input  logic                   C1,
    input  logic                   C3,
    input  logic                   tStart,
    input  chipBusPkg::cpuAddr_t   addr,
    input  logic                   rnw,
    input  logic [1:0]             siz,
    input  logic                   nDBR,
    input  logic                   casAgnus,
    output logic                   nAS,
    output logic                   nUDS,
    output logic                   nLDS,
    output logic                   nREGEN,
    output logic                   regTa,
    output logic                   regCycle,
    output chipBusPkg::regOffset_t regOffset
);

    chipBusPkg::phaseEvents_t phase;        // C1/C3 edge pulses
    chipBusPkg::regRequest_t  request;      // Latched CPU request
    logic                     regPending;

    //////////////////////////////////////////////////////////////////////
    // System clock phases
    //////////////////////////////////////////////////////////////////////

    clockPhaseTracker clockPhaseTracker_i (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .C1     (C1),
        .C3     (C3),
        .phase  (phase)
    );

    // CPU side, catches the register window
    regSpaceDecoder regSpaceDecoder_i (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .tStart     (tStart),
        .addr       (addr),
        .rnw        (rnw),
        .siz        (siz),
        .regTa      (regTa),        // Acknowledge frees the request
        .regPending (regPending),
        .request    (request)
    );

    // Emulated 68000 cycle toward Agnus and the custom chips
    chipRegisterCycle chipRegisterCycle_i (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .phase      (phase),
        .regPending (regPending),
        .request    (request),
        .nDBR       (nDBR),
        .casAgnus   (casAgnus),
        .nAS        (nAS),
        .nUDS       (nUDS),
        .nLDS       (nLDS),
        .nREGEN     (nREGEN),
        .regTa      (regTa),
        .regCycle   (regCycle),
        .regOffset  (regOffset)
    );

endmodule

// ==== sim/chipBusChecker.sv ====
`timescale 1ns/100ps

module chipBusChecker (
    input  logic                   CLK40,
    input  logic                   nRESET,
    input  logic                   C3,
    input  logic                   tStart,
    input  chipBusPkg::cpuAddr_t   addr,
    input  logic                   rnw,
    input  logic [1:0]             siz,
    input  logic                   nDBR,
    input  logic                   casAgnus,
    input  logic                   nAS,
    input  logic                   nUDS,
    input  logic                   nLDS,
    input  logic                   nREGEN,
    input  logic                   regTa,
    input  logic                   regCycle,
    input  chipBusPkg::regOffset_t regOffset,
    output int                     errorCount
);

    int                     errs = 0;
    logic                   busy = 1'b0;        // Request latched, acknowledge still due
    logic                   expRnw = 1'b1;
    logic                   expUpper = 1'b0;
    logic                   expLower = 1'b0;
    chipBusPkg::regOffset_t expOffset = '0;
    logic                   cycleTa = 1'b0;     // Acknowledge seen in this cycle
    logic                   freeRise = 1'b0;    // A C3 rise found the bus free
    logic                   strobeSeen = 1'b0;  // Some data strobe fell in this cycle
    logic                   prevNAS = 1'b1;
    logic                   prevC3 = 1'b0;
    logic                   inWindow;
    logic                   lanesOk;
    logic                   anyStrobe;

    assign errorCount = errs;
    assign inWindow   = (addr & chipBusPkg::REG_MASK) == chipBusPkg::REG_BASE;
    assign lanesOk    = (nUDS == !expUpper) && (nLDS == !expLower);
    assign anyStrobe  = !nUDS || !nLDS;

    task automatic reportMismatch(input string msg);
        errs++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sampled on the falling clock, between DUT updates
    //////////////////////////////////////////////////////////////////////

    always @(negedge CLK40) begin
        if (!nRESET) begin
            if (nAS !== 1'b1 || nUDS !== 1'b1 || nLDS !== 1'b1 || nREGEN !== 1'b1)
                reportMismatch("strobes not high during reset");
            if (regTa !== 1'b0 || regCycle !== 1'b0)
                reportMismatch("regTa or regCycle not low during reset");
            busy       = 1'b0;
            cycleTa    = 1'b0;
            freeRise   = 1'b0;
            strobeSeen = 1'b0;
        end else begin
            // A start while busy is dropped by the bridge
            if (tStart && inWindow && !busy) begin
                busy      = 1'b1;
                expRnw    = rnw;
                expUpper  = !addr[0];                       // Even address uses D15..D8
                expLower  = !(siz == 2'b01 && !addr[0]);    // Only an even byte skips D7..D0
                expOffset = addr[8:1];
            end

            if (prevNAS && !nAS) begin                      // S2
                if (!busy)
                    reportMismatch("address strobe without a pending request");
                cycleTa    = 1'b0;
                freeRise   = 1'b0;
                strobeSeen = 1'b0;
                if (regOffset != expOffset)
                    reportMismatch("regOffset differs from address bits 8 to 1");
                if (!expRnw && anyStrobe)
                    reportMismatch("write data strobe fell together with nAS");
            end

            // Buffer enable moves with the address strobe
            if (nREGEN != nAS)
                reportMismatch("nREGEN differs from nAS");

            if (!nAS) begin
                if (!regCycle)
                    reportMismatch("regCycle low during a register cycle");
                if (expRnw && !lanesOk)
                    reportMismatch("read data strobes do not match the byte lanes");
                if (!expRnw && anyStrobe && !lanesOk)
                    reportMismatch("write data strobes do not match the byte lanes");
                if (anyStrobe)
                    strobeSeen = 1'b1;
            end else begin
                if (anyStrobe)
                    reportMismatch("data strobe low while nAS is high");
                if (prevNAS && regCycle)
                    reportMismatch("regCycle still high after the cycle ended");
            end

            // Agnus is sampled on each C3 rise
            if (!prevC3 && C3 && !nAS) begin
                if (freeRise)
                    reportMismatch("no acknowledge after the bus was released");
                if (nDBR && !casAgnus)
                    freeRise = 1'b1;
            end

            if (regTa) begin
                if (!busy)
                    reportMismatch("acknowledge without a request");
                if (cycleTa)
                    reportMismatch("second acknowledge in one cycle");
                if (!freeRise)
                    reportMismatch("acknowledge before the bus was released");
                if (!nDBR || casAgnus)
                    reportMismatch("acknowledge while Agnus holds the bus");
                if (expRnw && nAS)
                    reportMismatch("read acknowledge outside the address strobe");
                if (!expRnw && !nAS)
                    reportMismatch("write acknowledge before nAS rose");
                cycleTa = 1'b1;
                busy    = 1'b0;
            end

            if (!prevNAS && nAS && !cycleTa)
                reportMismatch("register cycle ended without acknowledge");
            if (!prevNAS && nAS && !strobeSeen)
                reportMismatch("register cycle ended without a data strobe");
        end
        prevNAS = nAS;
        prevC3  = C3;
    end

endmodule

// ==== sim/chipBusTb.sv ====
`timescale 1ns/100ps

module chipBusTb;

    typedef struct packed {
        chipBusPkg::cpuAddr_t addr;
        logic                 rnw;
        logic [1:0]           siz;
        logic [3:0]           dbrHold;      // C3 rises with nDBR low
        logic [3:0]           casHold;      // C3 rises with casAgnus high
        logic                 randAddr;     // Bits 8..0 drawn at random
        logic                 busyPoke;     // Second start during the cycle
    } stimEntry_t;

    localparam int NUM_ENTRIES = 15;

    logic                   CLK40;
    logic                   nRESET;
    logic                   C1;
    logic                   C3;
    logic                   tStart;
    chipBusPkg::cpuAddr_t   addr;
    logic                   rnw;
    logic [1:0]             siz;
    logic                   nDBR;
    logic                   casAgnus;
    logic                   nAS;
    logic                   nUDS;
    logic                   nLDS;
    logic                   nREGEN;
    logic                   regTa;
    logic                   regCycle;
    chipBusPkg::regOffset_t regOffset;

    stimEntry_t stimTable [NUM_ENTRIES];
    logic [3:0] holdDbr;
    logic [3:0] holdCas;
    logic [3:0] risesSeen;      // C3 rises since nAS fell
    logic [1:0] stepIdx;
    int         seed;
    int         tbErrors;
    int         checkErrors;

    chipBusTop chipBusTop_i (
        .CLK40(CLK40), .nRESET(nRESET), .C1(C1), .C3(C3),
        .tStart(tStart), .addr(addr), .rnw(rnw), .siz(siz),
        .nDBR(nDBR), .casAgnus(casAgnus),
        .nAS(nAS), .nUDS(nUDS), .nLDS(nLDS), .nREGEN(nREGEN),
        .regTa(regTa), .regCycle(regCycle), .regOffset(regOffset)
    );

    chipBusChecker chipBusChecker_i (
        .CLK40(CLK40), .nRESET(nRESET), .C3(C3),
        .tStart(tStart), .addr(addr), .rnw(rnw), .siz(siz),
        .nDBR(nDBR), .casAgnus(casAgnus),
        .nAS(nAS), .nUDS(nUDS), .nLDS(nLDS), .nREGEN(nREGEN),
        .regTa(regTa), .regCycle(regCycle), .regOffset(regOffset),
        .errorCount(checkErrors)
    );

    initial begin
        CLK40 = 1'b0;
        forever #20 CLK40 = ~CLK40;     // 25 MHz stand-in for the 40 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // C1/C3 generator and Agnus model
    //////////////////////////////////////////////////////////////////////

    initial begin
        C1        = 1'b0;
        C3        = 1'b0;
        nDBR      = 1'b1;
        casAgnus  = 1'b0;
        risesSeen = 4'd0;
        stepIdx   = 2'd0;
        forever begin
            repeat (6) @(posedge CLK40);
            #2;
            case (stepIdx)
                2'd0: C1 = 1'b1;                // 00 -> 10
                2'd1: C3 = 1'b1;                // 10 -> 11
                2'd2: C1 = 1'b0;                // 11 -> 01
                default: begin
                    C3 = 1'b0;                  // 01 -> 00
                    // Agnus changes its pins halfway between C3 rises
                    if (!nAS && risesSeen != 4'hF)
                        risesSeen = risesSeen + 4'd1;
                end
            endcase
            if (nAS)
                risesSeen = 4'd0;               // No cycle running
            nDBR     = !(risesSeen < holdDbr);
            casAgnus = risesSeen < holdCas;
            stepIdx  = stepIdx + 2'd1;
        end
    end

    task automatic loadTable();
        // addr, rnw, siz, dbrHold, casHold, randAddr, busyPoke
        stimTable[0]  = '{24'hDFF180, 1'b1, 2'b10, 4'd0, 4'd0, 1'b0, 1'b0};  // Word read
        stimTable[1]  = '{24'hDFF096, 1'b0, 2'b10, 4'd0, 4'd0, 1'b0, 1'b0};  // Word write
        stimTable[2]  = '{24'hDFF0A1, 1'b1, 2'b01, 4'd0, 4'd0, 1'b0, 1'b0};  // Odd byte
        stimTable[3]  = '{24'hDFF0A0, 1'b0, 2'b01, 4'd0, 4'd0, 1'b0, 1'b0};  // Even byte
        stimTable[4]  = '{24'hDFF004, 1'b1, 2'b00, 4'd2, 4'd0, 1'b0, 1'b0};  // Long, DMA
        stimTable[5]  = '{24'hDFF035, 1'b0, 2'b11, 4'd0, 4'd2, 1'b0, 1'b0};
        stimTable[6]  = '{24'hDFF102, 1'b1, 2'b11, 4'd1, 4'd3, 1'b0, 1'b0};
        stimTable[7]  = '{24'hDFF09B, 1'b0, 2'b00, 4'd3, 4'd1, 1'b0, 1'b0};
        stimTable[8]  = '{24'hC00000, 1'b1, 2'b10, 4'd0, 4'd0, 1'b0, 1'b0};  // Slow RAM
        stimTable[9]  = '{24'hDFE000, 1'b0, 2'b10, 4'd0, 4'd0, 1'b0, 1'b0};  // Just below
        stimTable[10] = '{24'hDFF000, 1'b1, 2'b10, 4'd0, 4'd1, 1'b1, 1'b0};
        stimTable[11] = '{24'hDFF000, 1'b0, 2'b01, 4'd1, 4'd0, 1'b1, 1'b0};
        stimTable[12] = '{24'hDFF1FE, 1'b1, 2'b10, 4'd0, 4'd0, 1'b0, 1'b1};
        stimTable[13] = '{24'hDFF101, 1'b0, 2'b10, 4'd1, 4'd1, 1'b0, 1'b1};
        stimTable[14] = '{24'hE00000, 1'b1, 2'b10, 4'd0, 4'd0, 1'b1, 1'b0};
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bounded waits
    //////////////////////////////////////////////////////////////////////

    task automatic waitC3Fall(input int idx);
        int n;
        bit sawHigh;
        bit done;
        sawHigh = 1'b0;
        done    = 1'b0;
        for (n = 0; n < 60 && !done; n++) begin
            @(negedge CLK40);
            if (C3)
                sawHigh = 1'b1;
            else if (sawHigh)
                done = 1'b1;
        end
        if (!done) begin
            tbErrors++;
            $display("TIMEOUT at %0t: C3 never fell before entry %0d", $time, idx);
        end
    endtask

    task automatic waitAck(input int idx);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < 200 && !seen; n++) begin
            @(negedge CLK40);
            seen = regTa;
        end
        if (!seen) begin
            tbErrors++;
            $display("TIMEOUT at %0t: entry %0d got no acknowledge in 200 cycles", $time, idx);
        end
    endtask

    task automatic waitAddrStrobe(input logic level, input int idx);
        int n;
        bit done;
        done = 1'b0;
        for (n = 0; n < 100 && !done; n++) begin
            @(negedge CLK40);
            done = (nAS == level);
        end
        if (!done) begin
            tbErrors++;
            $display("TIMEOUT at %0t: nAS never went to %0b in entry %0d", $time, level, idx);
        end
    endtask

    task automatic pulseStart(input chipBusPkg::cpuAddr_t a, input logic dir,
                              input logic [1:0] size);
        @(posedge CLK40);
        #2;
        tStart = 1'b1;
        addr   = a;
        rnw    = dir;
        siz    = size;
        @(posedge CLK40);
        #2;
        tStart = 1'b0;
    endtask

    task automatic runEntry(input int idx);
        stimEntry_t           e;
        chipBusPkg::cpuAddr_t a;
        logic [31:0]          rnd;
        e = stimTable[idx];
        a = e.addr;
        if (e.randAddr) begin
            rnd     = $random(seed);
            a[8:0]  = rnd[8:0];
        end
        holdDbr = e.dbrHold;
        holdCas = e.casHold;
        waitC3Fall(idx);                        // Start lands just before S2
        pulseStart(a, e.rnw, e.siz);
        if ((a & chipBusPkg::REG_MASK) == chipBusPkg::REG_BASE) begin
            if (e.busyPoke) begin
                // Back-to-back start while the first is still pending
                tStart = 1'b1;
                addr   = 24'hDFF1C0;
                rnw    = !e.rnw;
                @(posedge CLK40);
                #2;
                tStart = 1'b0;
                waitAddrStrobe(1'b0, idx);
                pulseStart(24'hDFF1C0, !e.rnw, 2'b10);     // Must be dropped
            end
            waitAck(idx);
            waitAddrStrobe(1'b1, idx);
        end else begin
            repeat (60) @(negedge CLK40);      // Checker flags any strobe here
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        nRESET   = 1'b0;
        tStart   = 1'b0;
        addr     = '0;
        rnw      = 1'b1;
        siz      = 2'b00;
        holdDbr  = 4'd0;
        holdCas  = 4'd0;
        seed     = 32'h5004;
        tbErrors = 0;
        loadTable();
        repeat (5) @(posedge CLK40);
        #2;
        nRESET = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            runEntry(i);
        end
        repeat (10) @(negedge CLK40);
        $display("Errors: checker %0d, testbench %0d", checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
common/chipBusPkg.sv
hdl/clockPhaseTracker.sv
chipReg/regSpaceDecoder.sv
chipReg/chipRegisterCycle.sv
hdl/chipBusTop.sv
sim/chipBusChecker.sv
sim/chipBusTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module chipBusTb -f filelist.f -o chipBusSim

simStatus=0
./obj_dir/chipBusSim > sim.log 2>&1 || simStatus=$?
cat sim.log

if [ "$simStatus" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
